// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

	// ======================================================================
	// widths and boot address
	// ======================================================================
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// funct3 and funct7 encodings of the supported subset.
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_WORD    = 3'b010;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [6:0] F7_BASE    = 7'b000_0000;
	localparam logic [6:0] F7_SUB     = 7'b010_0000;

	// ======================================================================
	// enums
	// ======================================================================
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b011_0111,
		OPC_OP_IMM = 7'b001_0011,
		OPC_OP     = 7'b011_0011,
		OPC_LOAD   = 7'b000_0011,
		OPC_STORE  = 7'b010_0011,
		OPC_BRANCH = 7'b110_0011,
		OPC_JAL    = 7'b110_1111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		WAIT_INSTR,
		EXECUTE,
		WAIT_DATA
	} ctrl_state_e;

	// ======================================================================
	// structs passed between stages
	// ======================================================================
	typedef struct packed {
		alu_op_e               alu_op;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       imm;
		logic                  reg_write;
		logic                  use_imm;
		logic                  is_load;
		logic                  is_store;
		logic                  is_branch;
		logic                  branch_on_ne;
		logic                  is_jal;
		logic                  illegal;
	} decoded_instr_t;

	typedef struct packed {
		logic            we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} lsu_req_t;

	typedef struct packed {
		logic            req;
		logic            we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} data_bus_req_t;

endpackage

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu import core_pkg::*; (
	input  alu_op_e         op_i,
	input  logic [XLEN-1:0] a_i,
	input  logic [XLEN-1:0] b_i,
	output logic [XLEN-1:0] result_o,
	output logic            equal_o
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;

	// results wrap at 32 bits.
	assign sum  = a_i + b_i;
	assign diff = a_i - b_i;

	always_comb begin
		case (op_i)
			ALU_ADD:    result_o = sum;
			ALU_SUB:    result_o = diff;
			ALU_AND:    result_o = a_i & b_i;
			ALU_OR:     result_o = a_i | b_i;
			ALU_XOR:    result_o = a_i ^ b_i;
			ALU_PASS_B: result_o = b_i;
			default:    result_o = '0;
		endcase
	end

	// branch compare.
	assign equal_o = (diff == '0);

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none

module register_file import core_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [REG_ADDR_W-1:0] raddr_a_i,
	input  logic [REG_ADDR_W-1:0] raddr_b_i,
	output logic [XLEN-1:0]       rdata_a_o,
	output logic [XLEN-1:0]       rdata_b_o,
	input  logic                  we_i,
	input  logic [REG_ADDR_W-1:0] waddr_i,
	input  logic [XLEN-1:0]       wdata_i
);

	// x1..x31, x0 has no storage.
	logic [XLEN-1:0] regs_q [1:31];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== decoder.sv ====
`default_nettype none

module decoder import core_pkg::*; (
	input  logic [XLEN-1:0] instr_i,
	output decoded_instr_t  dec_o
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// immediate formats, all sign extended from bit 31.
	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		dec_o        = '0;
		dec_o.alu_op = ALU_ADD;
		dec_o.rs1    = instr_i[19:15];
		dec_o.rs2    = instr_i[24:20];
		dec_o.rd     = instr_i[11:7];
		case (opcode)
			OPC_LUI: begin
				dec_o.alu_op    = ALU_PASS_B;
				dec_o.imm       = imm_u;
				dec_o.use_imm   = 1'b1;
				dec_o.reg_write = 1'b1;
			end
			OPC_OP_IMM, OPC_OP: begin
				dec_o.imm       = imm_i;
				dec_o.use_imm   = (opcode == OPC_OP_IMM);
				dec_o.reg_write = 1'b1;
				case (funct3)
					F3_ADD_SUB: dec_o.alu_op = ALU_ADD;
					F3_XOR:     dec_o.alu_op = ALU_XOR;
					F3_OR:      dec_o.alu_op = ALU_OR;
					F3_AND:     dec_o.alu_op = ALU_AND;
					default:    dec_o.illegal = 1'b1;
				endcase
				// register form: funct7 picks sub, only for funct3 000.
				if (opcode == OPC_OP) begin
					if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
						dec_o.alu_op = ALU_SUB;
					end else if (funct7 != F7_BASE) begin
						dec_o.illegal = 1'b1;
					end
				end
			end
			OPC_LOAD: begin
				dec_o.imm       = imm_i;
				dec_o.use_imm   = 1'b1;
				dec_o.is_load   = 1'b1;
				dec_o.reg_write = 1'b1;
				dec_o.illegal   = (funct3 != F3_WORD);
			end
			OPC_STORE: begin
				dec_o.imm      = imm_s;
				dec_o.use_imm  = 1'b1;
				dec_o.is_store = 1'b1;
				dec_o.illegal  = (funct3 != F3_WORD);
			end
			OPC_BRANCH: begin
				dec_o.alu_op       = ALU_SUB;
				dec_o.imm          = imm_b;
				dec_o.is_branch    = 1'b1;
				dec_o.branch_on_ne = (funct3 == F3_BNE);
				dec_o.illegal      = (funct3 != F3_BEQ) && (funct3 != F3_BNE);
			end
			OPC_JAL: begin
				dec_o.imm       = imm_j;
				dec_o.is_jal    = 1'b1;
				dec_o.reg_write = 1'b1;
			end
			default: dec_o.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none

module fetch_stage import core_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            fetch_enable_i,
	input  logic            next_pc_valid_i,
	input  logic [XLEN-1:0] next_pc_i,
	output logic            instr_req_o,
	output logic [XLEN-1:0] instr_addr_o,
	input  logic            instr_gnt_i,
	input  logic            instr_rvalid_i,
	input  logic [XLEN-1:0] instr_rdata_i,
	output logic            instr_valid_o,
	output logic [XLEN-1:0] instr_o,
	output logic [XLEN-1:0] pc_o,
	output logic            fetch_busy_o
);

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] instr_q;
	logic            boot_q;
	logic            req_q;
	logic            wait_q;
	logic            exec_q;
	logic            valid_q;
	logic            idle;
	logic            launch;

	// nothing on the bus and no instruction handed to the controller.
	assign idle   = ~req_q & ~wait_q & ~exec_q;
	assign launch = fetch_enable_i & (idle | next_pc_valid_i);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q    <= RESET_PC;
			boot_q  <= 1'b1;
			req_q   <= 1'b0;
			wait_q  <= 1'b0;
			exec_q  <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (next_pc_valid_i) begin
				pc_q   <= next_pc_i;
				exec_q <= 1'b0;
			end
			if (launch) begin
				req_q  <= 1'b1;
				boot_q <= 1'b0;
			end else if (req_q && instr_gnt_i) begin
				req_q  <= 1'b0;
				wait_q <= 1'b1;
			end
			if (wait_q && instr_rvalid_i) begin
				wait_q  <= 1'b0;
				exec_q  <= 1'b1;
				valid_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wait_q && instr_rvalid_i) begin
			instr_q <= instr_rdata_i;
		end
	end

	assign instr_req_o   = req_q;
	assign instr_addr_o  = pc_q;
	assign instr_valid_o = valid_q;
	assign instr_o       = instr_q;
	assign pc_o          = pc_q;
	// boot counts as busy until the first fetch goes out.
	assign fetch_busy_o  = boot_q | ~idle;

	a_instr_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

`default_nettype wire

// ==== controller.sv ====
`default_nettype none

module controller import core_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  instr_valid_i,
	input  logic [XLEN-1:0]       pc_i,
	input  decoded_instr_t        dec_i,
	output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
	output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
	input  logic [XLEN-1:0]       rs1_rdata_i,
	input  logic [XLEN-1:0]       rs2_rdata_i,
	input  logic [XLEN-1:0]       alu_result_i,
	input  logic                  alu_equal_i,
	output alu_op_e               alu_op_o,
	output logic [XLEN-1:0]       alu_a_o,
	output logic [XLEN-1:0]       alu_b_o,
	output logic                  lsu_start_o,
	output lsu_req_t              lsu_req_o,
	input  logic                  lsu_done_i,
	input  logic [XLEN-1:0]       lsu_rdata_i,
	output logic                  rf_we_o,
	output logic [REG_ADDR_W-1:0] rf_waddr_o,
	output logic [XLEN-1:0]       rf_wdata_o,
	output logic                  next_pc_valid_o,
	output logic [XLEN-1:0]       next_pc_o
);

	ctrl_state_e     state_q;
	ctrl_state_e     state_d;
	decoded_instr_t  dec_q;
	logic            legal;
	logic            is_mem;
	logic            taken;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] target;

	// an illegal instruction runs as a no-op.
	assign legal    = ~dec_q.illegal;
	assign is_mem   = legal & (dec_q.is_load | dec_q.is_store);
	assign pc_plus4 = pc_i + 32'd4;
	assign target   = pc_i + dec_q.imm;
	assign taken    = legal & (dec_q.is_jal |
		(dec_q.is_branch & (alu_equal_i ^ dec_q.branch_on_ne)));

	assign rf_raddr_a_o = dec_q.rs1;
	assign rf_raddr_b_o = dec_q.rs2;

	assign alu_op_o = dec_q.alu_op;
	assign alu_a_o  = rs1_rdata_i;
	assign alu_b_o  = dec_q.use_imm ? dec_q.imm : rs2_rdata_i;

	assign lsu_start_o     = (state_q == EXECUTE) & is_mem;
	assign lsu_req_o.we    = dec_q.is_store;
	assign lsu_req_o.addr  = alu_result_i;
	assign lsu_req_o.wdata = rs2_rdata_i;

	always_comb begin
		state_d         = state_q;
		next_pc_valid_o = 1'b0;
		case (state_q)
			WAIT_INSTR: begin
				if (instr_valid_i) begin
					state_d = EXECUTE;
				end
			end
			EXECUTE: begin
				if (is_mem) begin
					state_d = WAIT_DATA;
				end else begin
					next_pc_valid_o = 1'b1;
					state_d         = WAIT_INSTR;
				end
			end
			WAIT_DATA: begin
				if (lsu_done_i) begin
					next_pc_valid_o = 1'b1;
					state_d         = WAIT_INSTR;
				end
			end
			default: state_d = WAIT_INSTR;
		endcase
	end

	assign next_pc_o = taken ? target : pc_plus4;

	// write back in the cycle that completes the instruction.
	assign rf_we_o    = next_pc_valid_o & legal & dec_q.reg_write;
	assign rf_waddr_o = dec_q.rd;
	assign rf_wdata_o = dec_q.is_load ? lsu_rdata_i :
		dec_q.is_jal ? pc_plus4 : alu_result_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= WAIT_INSTR;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == WAIT_INSTR && instr_valid_i) begin
			dec_q <= dec_i;
		end
	end

	// the load-store unit only answers an access that is still awaited.
	a_lsu_done_in_wait_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lsu_done_i |-> state_q == WAIT_DATA);

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`default_nettype none

module load_store_unit import core_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            lsu_start_i,
	input  lsu_req_t        lsu_req_i,
	output logic            lsu_done_o,
	output logic [XLEN-1:0] lsu_rdata_o,
	output data_bus_req_t   bus_o,
	input  logic            data_gnt_i,
	input  logic            data_rvalid_i,
	input  logic [XLEN-1:0] data_rdata_i,
	output logic            lsu_busy_o
);

	lsu_req_t        req_data_q;
	logic [XLEN-1:0] rdata_q;
	logic            req_q;
	logic            wait_q;
	logic            done_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			req_q  <= 1'b0;
			wait_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (lsu_start_i) begin
				req_q <= 1'b1;
			end else if (req_q && data_gnt_i) begin
				req_q  <= 1'b0;
				wait_q <= 1'b1;
			end
			if (wait_q && data_rvalid_i) begin
				wait_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (lsu_start_i) begin
			req_data_q <= lsu_req_i;
		end
		// store responses land here too and are never used.
		if (wait_q && data_rvalid_i) begin
			rdata_q <= data_rdata_i;
		end
	end

	assign bus_o.req   = req_q;
	assign bus_o.we    = req_data_q.we;
	assign bus_o.addr  = req_data_q.addr;
	assign bus_o.wdata = req_data_q.wdata;

	assign lsu_done_o  = done_q;
	assign lsu_rdata_o = rdata_q;
	assign lsu_busy_o  = req_q | wait_q;

	a_rvalid_outstanding : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		data_rvalid_i |-> wait_q);

endmodule

`default_nettype wire

// ==== core_top.sv ====
`default_nettype none

module core_top import core_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            fetch_enable_i,
	output logic            instr_req_o,
	output logic [XLEN-1:0] instr_addr_o,
	input  logic            instr_gnt_i,
	input  logic            instr_rvalid_i,
	input  logic [XLEN-1:0] instr_rdata_i,
	output logic            data_req_o,
	output logic            data_we_o,
	output logic [XLEN-1:0] data_addr_o,
	output logic [XLEN-1:0] data_wdata_o,
	input  logic            data_gnt_i,
	input  logic            data_rvalid_i,
	input  logic [XLEN-1:0] data_rdata_i,
	output logic            core_busy_o
);

	logic                  instr_valid;
	logic [XLEN-1:0]       instr;
	logic [XLEN-1:0]       pc;
	logic                  fetch_busy;
	logic                  next_pc_valid;
	logic [XLEN-1:0]       next_pc;
	decoded_instr_t        dec;
	logic [REG_ADDR_W-1:0] rf_raddr_a;
	logic [REG_ADDR_W-1:0] rf_raddr_b;
	logic [XLEN-1:0]       rf_rdata_a;
	logic [XLEN-1:0]       rf_rdata_b;
	logic                  rf_we;
	logic [REG_ADDR_W-1:0] rf_waddr;
	logic [XLEN-1:0]       rf_wdata;
	alu_op_e               alu_op;
	logic [XLEN-1:0]       alu_a;
	logic [XLEN-1:0]       alu_b;
	logic [XLEN-1:0]       alu_result;
	logic                  alu_equal;
	logic                  lsu_start;
	lsu_req_t              lsu_req;
	logic                  lsu_done;
	logic [XLEN-1:0]       lsu_rdata;
	logic                  lsu_busy;
	data_bus_req_t         data_bus;

	// ======================================================================
	// fetch and decode
	// ======================================================================
	fetch_stage u_fetch_stage (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.fetch_enable_i  (fetch_enable_i),
		.next_pc_valid_i (next_pc_valid),
		.next_pc_i       (next_pc),
		.instr_req_o     (instr_req_o),
		.instr_addr_o    (instr_addr_o),
		.instr_gnt_i     (instr_gnt_i),
		.instr_rvalid_i  (instr_rvalid_i),
		.instr_rdata_i   (instr_rdata_i),
		.instr_valid_o   (instr_valid),
		.instr_o         (instr),
		.pc_o            (pc),
		.fetch_busy_o    (fetch_busy)
	);

	decoder u_decoder (
		.instr_i (instr),
		.dec_o   (dec)
	);

	controller u_controller (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.instr_valid_i   (instr_valid),
		.pc_i            (pc),
		.dec_i           (dec),
		.rf_raddr_a_o    (rf_raddr_a),
		.rf_raddr_b_o    (rf_raddr_b),
		.rs1_rdata_i     (rf_rdata_a),
		.rs2_rdata_i     (rf_rdata_b),
		.alu_result_i    (alu_result),
		.alu_equal_i     (alu_equal),
		.alu_op_o        (alu_op),
		.alu_a_o         (alu_a),
		.alu_b_o         (alu_b),
		.lsu_start_o     (lsu_start),
		.lsu_req_o       (lsu_req),
		.lsu_done_i      (lsu_done),
		.lsu_rdata_i     (lsu_rdata),
		.rf_we_o         (rf_we),
		.rf_waddr_o      (rf_waddr),
		.rf_wdata_o      (rf_wdata),
		.next_pc_valid_o (next_pc_valid),
		.next_pc_o       (next_pc)
	);

	// ======================================================================
	// execute, registers and memory access
	// ======================================================================
	alu u_alu (
		.op_i     (alu_op),
		.a_i      (alu_a),
		.b_i      (alu_b),
		.result_o (alu_result),
		.equal_o  (alu_equal)
	);

	register_file u_register_file (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.raddr_a_i (rf_raddr_a),
		.raddr_b_i (rf_raddr_b),
		.rdata_a_o (rf_rdata_a),
		.rdata_b_o (rf_rdata_b),
		.we_i      (rf_we),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata)
	);

	load_store_unit u_load_store_unit (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.lsu_start_i   (lsu_start),
		.lsu_req_i     (lsu_req),
		.lsu_done_o    (lsu_done),
		.lsu_rdata_o   (lsu_rdata),
		.bus_o         (data_bus),
		.data_gnt_i    (data_gnt_i),
		.data_rvalid_i (data_rvalid_i),
		.data_rdata_i  (data_rdata_i),
		.lsu_busy_o    (lsu_busy)
	);

	assign data_req_o   = data_bus.req;
	assign data_we_o    = data_bus.we;
	assign data_addr_o  = data_bus.addr;
	assign data_wdata_o = data_bus.wdata;

	assign core_busy_o = fetch_busy | lsu_busy;

endmodule

`default_nettype wire

// ==== tb_core.sv ====
`default_nettype none

module tb_core;

	localparam int WAIT_LIMIT = 1000;

	logic        clk_i;
	logic        rst_n_i;
	logic        fetch_enable_i;
	logic        instr_req_o;
	logic [31:0] instr_addr_o;
	logic        instr_gnt_i;
	logic        instr_rvalid_i;
	logic [31:0] instr_rdata_i;
	logic        data_req_o;
	logic        data_we_o;
	logic [31:0] data_addr_o;
	logic [31:0] data_wdata_o;
	logic        data_gnt_i;
	logic        data_rvalid_i;
	logic [31:0] data_rdata_i;
	logic        core_busy_o;

	// program image, data memory and the expected stores.
	logic [31:0] prog [$];
	logic [31:0] dmem [0:15];
	logic [31:0] gold_addr [0:15];
	logic [31:0] gold_data [0:15];
	int          n_stores;
	int          store_idx;
	int          mark [0:4];
	int          self_pc;

	int          seed;
	int          errors;
	int          err_mark;
	int          tests_run;
	int          tests_failed;

	// bus model state. phase 0 idle, 1 before grant, 2 before response.
	int          i_phase;
	int          i_cnt;
	logic [31:0] i_addr;
	int          d_phase;
	int          d_cnt;
	logic [31:0] d_addr;
	logic [31:0] d_wdata;
	logic        d_we;

	logic        store_hs;
	logic        exp_valid;
	logic [31:0] exp_addr;
	logic [31:0] exp_data;

	core_top DUT (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.fetch_enable_i (fetch_enable_i),
		.instr_req_o    (instr_req_o),
		.instr_addr_o   (instr_addr_o),
		.instr_gnt_i    (instr_gnt_i),
		.instr_rvalid_i (instr_rvalid_i),
		.instr_rdata_i  (instr_rdata_i),
		.data_req_o     (data_req_o),
		.data_we_o      (data_we_o),
		.data_addr_o    (data_addr_o),
		.data_wdata_o   (data_wdata_o),
		.data_gnt_i     (data_gnt_i),
		.data_rvalid_i  (data_rvalid_i),
		.data_rdata_i   (data_rdata_i),
		.core_busy_o    (core_busy_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ====================================================================
	// instruction encoding and program image
	// ====================================================================
	function automatic logic [31:0] r_type(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [2:0] f3, input logic [6:0] f7);
		return {f7, rs2, rs1, f3, rd, 7'b011_0011};
	endfunction

	function automatic logic [31:0] i_type(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm, input logic [2:0] f3);
		return {imm, rs1, f3, rd, 7'b001_0011};
	endfunction

	function automatic logic [31:0] lw_type(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b000_0011};
	endfunction

	function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b010_0011};
	endfunction

	function automatic logic [31:0] b_type(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] off, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b110_0011};
	endfunction

	function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b011_0111};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
	endfunction

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		gold_addr[n_stores] = addr;
		gold_data[n_stores] = data;
		n_stores++;
	endtask

	task automatic build_program();
		logic [31:0] x1;
		logic [31:0] x5;
		int          jal_pc;
		// arithmetic and logic, x10 is the data base.
		prog.push_back(u_type(5'd1, 20'h80000));
		prog.push_back(i_type(5'd1, 5'd1, 12'hFFF, 3'b000));
		prog.push_back(i_type(5'd2, 5'd0, 12'h001, 3'b000));
		prog.push_back(i_type(5'd10, 5'd0, 12'h100, 3'b000));
		prog.push_back(r_type(5'd3, 5'd1, 5'd2, 3'b000, 7'h00));
		prog.push_back(s_type(5'd3, 5'd10, 12'h000));
		prog.push_back(r_type(5'd4, 5'd0, 5'd2, 3'b000, 7'h20));
		prog.push_back(s_type(5'd4, 5'd10, 12'h004));
		prog.push_back(u_type(5'd5, 20'hF0F0F));
		prog.push_back(r_type(5'd6, 5'd5, 5'd1, 3'b111, 7'h00));
		prog.push_back(s_type(5'd6, 5'd10, 12'h008));
		prog.push_back(r_type(5'd7, 5'd5, 5'd1, 3'b100, 7'h00));
		prog.push_back(s_type(5'd7, 5'd10, 12'h00C));
		prog.push_back(r_type(5'd8, 5'd6, 5'd2, 3'b110, 7'h00));
		prog.push_back(s_type(5'd8, 5'd10, 12'h010));
		x1 = 32'h8000_0000 + 32'hFFFF_FFFF;
		x5 = 32'hF0F0_F000;
		expect_store(32'h100, x1 + 32'd1);
		expect_store(32'h104, 32'd0 - 32'd1);
		expect_store(32'h108, x5 & x1);
		expect_store(32'h10C, x5 ^ x1);
		expect_store(32'h110, (x5 & x1) | 32'd1);
		mark[0] = n_stores;
		// loads from the preset words at 0x120 and 0x124.
		prog.push_back(lw_type(5'd11, 5'd10, 12'h020));
		prog.push_back(i_type(5'd11, 5'd11, 12'h123, 3'b000));
		prog.push_back(s_type(5'd11, 5'd10, 12'h014));
		prog.push_back(lw_type(5'd12, 5'd10, 12'h024));
		prog.push_back(i_type(5'd12, 5'd12, 12'hFF8, 3'b000));
		prog.push_back(s_type(5'd12, 5'd10, 12'h018));
		expect_store(32'h114, dmem[8] + 32'h123);
		expect_store(32'h118, dmem[9] - 32'd8);
		mark[1] = n_stores;
		// stores to 0x138 sit on skipped paths.
		prog.push_back(b_type(5'd2, 5'd0, 13'd8, 3'b000));
		prog.push_back(s_type(5'd2, 5'd10, 12'h01C));
		prog.push_back(b_type(5'd2, 5'd0, 13'd8, 3'b001));
		prog.push_back(s_type(5'd0, 5'd10, 12'h038));
		prog.push_back(b_type(5'd4, 5'd4, 13'd8, 3'b000));
		prog.push_back(s_type(5'd4, 5'd10, 12'h038));
		prog.push_back(b_type(5'd1, 5'd1, 13'd8, 3'b001));
		prog.push_back(s_type(5'd1, 5'd10, 12'h028));
		expect_store(32'h11C, 32'd1);
		expect_store(32'h128, x1);
		mark[2] = n_stores;
		jal_pc = prog.size() * 4;
		prog.push_back(j_type(5'd13, 21'd8));
		prog.push_back(s_type(5'd0, 5'd10, 12'h03C));
		prog.push_back(s_type(5'd13, 5'd10, 12'h02C));
		expect_store(32'h12C, jal_pc + 4);
		mark[3] = n_stores;
		prog.push_back(i_type(5'd0, 5'd0, 12'h055, 3'b000));
		prog.push_back(r_type(5'd0, 5'd1, 5'd2, 3'b000, 7'h00));
		prog.push_back(s_type(5'd0, 5'd10, 12'h030));
		expect_store(32'h130, 32'd0);
		mark[4] = n_stores;
		self_pc = prog.size() * 4;
		prog.push_back(j_type(5'd0, 21'd0));
	endtask

	// words past the program decode as illegal.
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if ((addr >> 2) < prog.size()) begin
			return prog[addr >> 2];
		end
		return {addr[24:0] ^ addr[31:7], 7'h7F};
	endfunction

	// ====================================================================
	// bus models with random grant and response delays
	// ====================================================================
	function automatic int random_delay();
		return $unsigned($random(seed)) % 32'd4;
	endfunction

	task automatic step_imem();
		instr_gnt_i    = 1'b0;
		instr_rvalid_i = 1'b0;
		if (i_phase == 2) begin
			if (i_cnt == 0) begin
				instr_rvalid_i = 1'b1;
				instr_rdata_i  = fetch_word(i_addr);
				i_phase        = 0;
			end else begin
				i_cnt--;
			end
		end else if (i_phase == 0 && instr_req_o) begin
			i_addr  = instr_addr_o;
			i_cnt   = random_delay();
			i_phase = 1;
		end
		if (i_phase == 1) begin
			if (i_cnt == 0) begin
				instr_gnt_i = 1'b1;
				i_cnt       = random_delay();
				i_phase     = 2;
			end else begin
				i_cnt--;
			end
		end
	endtask

	task automatic step_dmem();
		data_gnt_i    = 1'b0;
		data_rvalid_i = 1'b0;
		if (d_phase == 2) begin
			if (d_cnt == 0) begin
				data_rvalid_i = 1'b1;
				data_rdata_i  = dmem[d_addr[5:2]];
				if (d_we) begin
					dmem[d_addr[5:2]] = d_wdata;
				end
				d_phase = 0;
			end else begin
				d_cnt--;
			end
		end else if (d_phase == 0 && data_req_o) begin
			d_addr  = data_addr_o;
			d_wdata = data_wdata_o;
			d_we    = data_we_o;
			d_cnt   = random_delay();
			d_phase = 1;
		end
		if (d_phase == 1) begin
			if (d_cnt == 0) begin
				data_gnt_i = 1'b1;
				d_cnt      = random_delay();
				d_phase    = 2;
			end else begin
				d_cnt--;
			end
		end
	endtask

	initial begin
		forever begin
			@(posedge clk_i);
			#1;
			step_imem();
			step_dmem();
		end
	end

	// ====================================================================
	// checks
	// ====================================================================
	assign store_hs  = data_req_o & data_gnt_i & data_we_o;
	assign exp_valid = (store_idx < n_stores);
	assign exp_addr  = gold_addr[store_idx[3:0]];
	assign exp_data  = gold_data[store_idx[3:0]];

	// each granted store moves on to the next golden entry.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			store_idx <= 0;
		end else if (store_hs) begin
			store_idx <= store_idx + 1;
		end
	end

	a_store_expected : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		store_hs |-> exp_valid)
		else begin
			$display("store to %h was not expected by the program", $sampled(data_addr_o));
			errors++;
		end

	a_store_addr : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		store_hs && exp_valid |-> data_addr_o == exp_addr)
		else begin
			$display("ERR data_addr_o expected %h got %h", $sampled(exp_addr),
				$sampled(data_addr_o));
			errors++;
		end

	a_store_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		store_hs && exp_valid |-> data_wdata_o == exp_data)
		else begin
			$display("ERR data_wdata_o expected %h got %h", $sampled(exp_data),
				$sampled(data_wdata_o));
			errors++;
		end

	a_instr_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
		else begin
			$display("instruction request dropped or moved before its grant");
			errors++;
		end

	a_data_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
		$stable(data_we_o) && $stable(data_wdata_o))
		else begin
			$display("data request dropped or changed before its grant");
			errors++;
		end

	task automatic report_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic wait_stores(input string name, input int target);
		int cycles;
		cycles = 0;
		while (store_idx < target && cycles < WAIT_LIMIT) begin
			@(posedge clk_i);
			#1;
			cycles++;
		end
		if (store_idx < target) begin
			$display("test %s: timed out after %0d cycles waiting for store %0d",
				name, cycles, target);
			errors++;
		end
		report_test(name);
	endtask

	// ====================================================================
	// test sequence
	// ====================================================================
	initial begin
		int cycles;
		seed           = 6;
		errors         = 0;
		err_mark       = 0;
		tests_run      = 0;
		tests_failed   = 0;
		n_stores       = 0;
		i_phase        = 0;
		d_phase        = 0;
		rst_n_i        = 1'b0;
		fetch_enable_i = 1'b1;
		instr_gnt_i    = 1'b0;
		instr_rvalid_i = 1'b0;
		instr_rdata_i  = '0;
		data_gnt_i     = 1'b0;
		data_rvalid_i  = 1'b0;
		data_rdata_i   = '0;
		for (int i = 0; i < 16; i++) begin
			dmem[i] = (32'h100 + 4 * i) * 32'h0001_0003 ^ 32'hA5A5_0000;
		end
		build_program();

		repeat (2) begin
			@(posedge clk_i);
			#1;
			assert (!instr_req_o && !data_req_o) else begin
				$display("bus request raised during reset");
				errors++;
			end
		end
		rst_n_i = 1'b1;
		@(posedge clk_i);
		#1;
		assert (instr_req_o && core_busy_o) else begin
			$display("no instruction request in the first cycle after reset");
			errors++;
		end
		report_test("reset");

		wait_stores("arith", mark[0]);
		wait_stores("loads", mark[1]);
		wait_stores("branches", mark[2]);
		wait_stores("jal", mark[3]);
		wait_stores("x0_stall", mark[4]);

		// stop fetching once the closing self-jump is requested.
		cycles = 0;
		while (!(instr_req_o && instr_addr_o == self_pc) && cycles < WAIT_LIMIT) begin
			@(posedge clk_i);
			#1;
			cycles++;
		end
		if (!(instr_req_o && instr_addr_o == self_pc)) begin
			$display("core never fetched the closing self-jump");
			errors++;
		end
		fetch_enable_i = 1'b0;
		cycles = 0;
		while (core_busy_o && cycles < WAIT_LIMIT) begin
			@(posedge clk_i);
			#1;
			cycles++;
		end
		if (core_busy_o) begin
			$display("core stayed busy after fetch enable dropped");
			errors++;
		end
		repeat (20) begin
			@(posedge clk_i);
			#1;
			assert (!instr_req_o) else begin
				$display("new instruction request after the core went idle");
				errors++;
			end
		end
		report_test("idle");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
core_pkg.sv
alu.sv
register_file.sv
decoder.sv
fetch_stage.sv
controller.sv
load_store_unit.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_core
FILELIST  = vlog.f

.PHONY: run lint clean

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
